//--- bench/core_cases.txt
# P <address> <instruction word, stored little-endian>
# S <store address> <store data>, expected in order
P 00 07F00093
P 04 00208113
P 08 0C200023
P 0C 001121B3
P 10 40208233
P 14 0C3000A3
P 18 0C400123
P 1C 0C000283
P 20 00128293
P 24 0C5001A3
P 28 00114463
P 2C 0C100223
P 30 0080036F
P 34 0C100223
P 38 0C6002A3
P 3C 0000006F
S C0 81
S C1 01
S C2 FE
S C3 82
S C5 34

//--- sim.f
source/core_pkg.sv
source/mem_if.sv
source/fetch.sv
source/decode.sv
source/exec.sv
source/writeback.sv
source/sequencer.sv
source/eightbit.sv
bench/eightbit_tb.sv

//--- bench/eightbit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eightbit_tb import core_pkg::*; ();

    localparam int WAIT_LIMIT = 20000;
    localparam int QUIET_CYCLES = 200;

    logic clk;
    logic rst;
    word_t data_in;
    word_t data_out;
    word_t addr;
    logic we;

    word_t mem [256];
    word_t exp_addr [$];
    word_t exp_data [$];
    int errors;
    int stores_seen;
    logic rst_held;

    eightbit eightbit_inst (
        .clk(clk), .rst(rst), .data_in(data_in), .data_out(data_out),
        .addr(addr), .we(we)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    // Load program words little-endian and queue the expected stores
    task automatic load_cases();
        int fd;
        int a;
        logic [31:0] w;
        string line;
        fd = $fopen("bench/core_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "P %h %h", a, w) == 2) begin
                for (int i = 0; i < 4; i++)
                    mem[(a + i) % 256] = w[8*i +: 8];
            end else if ($sscanf(line, "S %h %h", a, w) == 2) begin
                exp_addr.push_back(word_t'(a));
                exp_data.push_back(word_t'(w));
            end
        end
        $fclose(fd);
    endtask

    // Synchronous byte memory
    always @(posedge clk) begin
        data_in <= mem[addr];
        if (we)
            mem[addr] <= data_out;
    end

    // Store monitor
    always @(posedge clk) begin
        if (rst) begin
            if (rst_held) begin // Bus settles one edge into reset
                if (we) begin
                    $display("Store issued while reset was held");
                    errors++;
                end
                check_addr("addr", addr, 8'h00);
                check_word("data_out", data_out, 8'h00);
            end
        end else if (we) begin
            if (stores_seen < exp_addr.size()) begin
                check_addr("addr", addr, exp_addr[stores_seen]);
                check_word("data_out", data_out, exp_data[stores_seen]);
            end else begin
                $display("Unexpected extra store to 0x%02h", addr);
                errors++;
            end
            stores_seen++;
        end
        rst_held <= rst;
    end

    initial begin
        int cycles;
        errors = 0;
        stores_seen = 0;
        rst_held = 1'b0;
        rst = 1'b1;
        data_in = '0;
        void'($urandom(37385));
        for (int i = 0; i < 256; i++)
            mem[i] = word_t'($urandom);
        load_cases();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        cycles = 0;
        while (stores_seen < exp_addr.size() && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (stores_seen < exp_addr.size()) begin
            $display("Timeout, the program never finished its stores");
            $display("errors: %0d", errors + 1);
            $display("test failed");
            $finish;
        end else begin
            repeat (QUIET_CYCLES) @(posedge clk); // Extra stores caught by monitor
            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- source/eightbit.sv
`timescale 1ns/1ps
`default_nettype none

module eightbit import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t data_in,
    output word_t data_out,
    output word_t addr,
    output logic  we
);

    logic fetch_en, fetch_ready, fetch_req, fetch_mem_ready;
    word_t fetch_pc, fetch_addr;
    inst_t fetch_inst, decode_inst;
    logic decode_en, decode_ready;
    op_class_t decode_class, exec_class;
    alu_fn_t decode_fn, exec_fn;
    reg_addr_t decode_rd, decode_rs1, decode_rs2, rs1_addr, rs2_addr, wb_rd;
    word_t decode_imm, rs1_val, rs2_val;
    logic exec_en, exec_ready, exec_flush, exec_req, exec_we, exec_mem_ready;
    word_t exec_pc, exec_rs1, exec_rs2, exec_imm, exec_val, exec_pc_out;
    word_t exec_addr, exec_wdata;
    logic wb_en, wb_ready;
    word_t wb_val;

    sequencer seq (
        .clk(clk), .rst(rst),
        .fetch_ready(fetch_ready), .fetch_inst(fetch_inst),
        .decode_ready(decode_ready), .decode_class(decode_class), .decode_fn(decode_fn),
        .decode_rd(decode_rd), .decode_rs1(decode_rs1), .decode_rs2(decode_rs2),
        .decode_imm(decode_imm), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .exec_ready(exec_ready), .exec_flush(exec_flush), .exec_pc_out(exec_pc_out),
        .exec_val(exec_val), .wb_ready(wb_ready),
        .fetch_en(fetch_en), .fetch_pc(fetch_pc), .decode_en(decode_en),
        .decode_inst(decode_inst), .exec_en(exec_en), .exec_class(exec_class),
        .exec_fn(exec_fn), .exec_pc(exec_pc), .exec_rs1(exec_rs1), .exec_rs2(exec_rs2),
        .exec_imm(exec_imm), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_val(wb_val)
    );

    fetch fetch_stage (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(fetch_pc), .data_in(data_in),
        .mem_ready(fetch_mem_ready), .mem_req(fetch_req), .addr(fetch_addr),
        .inst(fetch_inst), .ready(fetch_ready)
    );

    decode decode_stage (
        .clk(clk), .rst(rst), .en(decode_en), .inst(decode_inst),
        .op_class(decode_class), .alu_fn(decode_fn), .rd(decode_rd),
        .rs1(decode_rs1), .rs2(decode_rs2), .imm(decode_imm), .ready(decode_ready)
    );

    exec exec_stage (
        .clk(clk), .rst(rst), .en(exec_en), .op_class(exec_class), .alu_fn(exec_fn),
        .pc(exec_pc), .rs1(exec_rs1), .rs2(exec_rs2), .imm(exec_imm), .data_in(data_in),
        .mem_ready(exec_mem_ready), .val(exec_val), .mem_req(exec_req), .mem_we(exec_we),
        .mem_addr(exec_addr), .mem_wdata(exec_wdata), .pc_out(exec_pc_out),
        .flush(exec_flush), .ready(exec_ready)
    );

    writeback wb_stage (
        .clk(clk), .rst(rst), .en(wb_en), .rd(wb_rd), .val(wb_val),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .ready(wb_ready)
    );

    mem_if mem_arb (
        .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .exec_req(exec_req), .exec_addr(exec_addr), .exec_we(exec_we),
        .exec_wdata(exec_wdata), .fetch_ready(fetch_mem_ready),
        .exec_ready(exec_mem_ready), .addr(addr), .we(we), .data_out(data_out)
    );

endmodule

`default_nettype wire

//--- source/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      fetch_ready,
    input  inst_t     fetch_inst,
    input  logic      decode_ready,
    input  op_class_t decode_class,
    input  alu_fn_t   decode_fn,
    input  reg_addr_t decode_rd,
    input  reg_addr_t decode_rs1,
    input  reg_addr_t decode_rs2,
    input  word_t     decode_imm,
    input  word_t     rs1_val,
    input  word_t     rs2_val,
    input  logic      exec_ready,
    input  logic      exec_flush,
    input  word_t     exec_pc_out,
    input  word_t     exec_val,
    input  logic      wb_ready,
    output logic      fetch_en,
    output word_t     fetch_pc,
    output logic      decode_en,
    output inst_t     decode_inst,
    output logic      exec_en,
    output op_class_t exec_class,
    output alu_fn_t   exec_fn,
    output word_t     exec_pc,
    output word_t     exec_rs1,
    output word_t     exec_rs2,
    output word_t     exec_imm,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      wb_en,
    output reg_addr_t wb_rd,
    output word_t     wb_val
);

    stage_state_t fetch_state, decode_state, exec_state, wb_state;
    word_t pc, decode_pc;
    reg_addr_t exec_rd;
    logic fetch_go, decode_go, exec_go, wb_go, wb_write;

    assign fetch_state = stage_state_t'({fetch_en, fetch_ready});
    assign decode_state = stage_state_t'({decode_en, decode_ready});
    assign exec_state = stage_state_t'({exec_en, exec_ready});
    assign wb_state = stage_state_t'({wb_en, wb_ready});

    assign fetch_go = fetch_state == st_idle;
    assign decode_go = fetch_state == st_complete && decode_state == st_idle;
    assign exec_go = decode_state == st_complete
                     && exec_state inside {st_idle, st_resetting}
                     && wb_state inside {st_idle, st_resetting}; // Prior write has landed
    assign wb_go = exec_state == st_complete && wb_state inside {st_idle, st_resetting};
    assign wb_write = !(exec_class inside {cls_none, cls_store, cls_branch})
                      && exec_rd != '0;

    assign rs1_addr = decode_rs1;
    assign rs2_addr = decode_rs2;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetch_en <= 1'b0;
            decode_en <= 1'b0;
            exec_en <= 1'b0;
            wb_en <= 1'b0;
        end else begin
            if (fetch_go)
                fetch_en <= 1'b1;
            if (decode_go) begin
                fetch_en <= 1'b0;
                decode_en <= 1'b1;
                pc <= pc + word_t'(INST_BYTES);
            end
            if (exec_go) begin
                decode_en <= 1'b0;
                exec_en <= 1'b1;
            end
            if (wb_go) begin
                exec_en <= 1'b0;
                wb_en <= wb_write;
                if (exec_flush) begin // Overrides the starts above
                    pc <= exec_pc_out;
                    fetch_en <= 1'b0;
                    decode_en <= 1'b0;
                end
            end
            if (wb_state == st_complete)
                wb_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go)
            fetch_pc <= pc;
        if (decode_go) begin
            decode_inst <= fetch_inst;
            decode_pc <= fetch_pc;
        end
        if (exec_go) begin
            exec_class <= decode_class;
            exec_fn <= decode_fn;
            exec_pc <= decode_pc;
            exec_rs1 <= rs1_val;
            exec_rs2 <= rs2_val;
            exec_imm <= decode_imm;
            exec_rd <= decode_rd;
        end
        if (wb_go) begin
            wb_rd <= exec_rd;
            wb_val <= exec_val;
        end
    end

    // Wrong-path instruction must not reach decode
    flush_kills_decode: assert property (@(posedge clk) disable iff (rst)
        wb_go && exec_flush |=> !decode_en ##1 !(fetch_ready || decode_ready));

endmodule

`default_nettype wire

//--- source/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  reg_addr_t rd,
    input  word_t     val,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_val,
    output word_t     rs2_val,
    output logic      ready
);

    word_t regs [REG_CNT];

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_CNT; i++)
                regs[i] <= '0;
            ready <= 1'b0;
        end else begin
            ready <= en;
            if (en && !ready)
                regs[rd] <= val;
        end
    end

    x0_stays_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

`default_nettype wire

//--- source/exec.sv
`timescale 1ns/1ps
`default_nettype none

module exec import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  op_class_t op_class,
    input  alu_fn_t   alu_fn,
    input  word_t     pc,
    input  word_t     rs1,
    input  word_t     rs2,
    input  word_t     imm,
    input  word_t     data_in,
    input  logic      mem_ready,
    output word_t     val,
    output logic      mem_req,
    output logic      mem_we,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    output word_t     pc_out,
    output logic      flush,
    output logic      ready
);

    logic is_mem, taken;
    word_t b_op, alu_res, link;

    assign is_mem = op_class inside {cls_load, cls_store};
    assign mem_req = en && !ready && is_mem;
    assign mem_we = op_class == cls_store;
    assign mem_addr = rs1 + imm; // Also the JALR target
    assign mem_wdata = rs2;
    assign b_op = rs2 + imm; // One of the two is zero
    assign link = pc + word_t'(INST_BYTES);

    always_comb begin
        case (alu_fn)
            alu_sub: alu_res = rs1 - b_op;
            alu_xor: alu_res = rs1 ^ b_op;
            alu_or:  alu_res = rs1 | b_op;
            alu_and: alu_res = rs1 & b_op;
            alu_slt: alu_res = word_t'($signed(rs1) < $signed(b_op));
            alu_sll: alu_res = rs1 << b_op[2:0];
            alu_srl: alu_res = rs1 >> b_op[2:0];
            default: alu_res = rs1 + b_op;
        endcase
    end

    always_comb begin
        case (alu_fn)
            alu_beq: taken = rs1 == rs2;
            alu_bne: taken = rs1 != rs2;
            alu_blt: taken = $signed(rs1) < $signed(rs2);
            alu_bge: taken = $signed(rs1) >= $signed(rs2);
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || !en) begin
            ready <= 1'b0;
            flush <= 1'b0;
        end else if (!ready) begin
            if (!is_mem) begin
                ready <= 1'b1;
                flush <= op_class inside {cls_jal, cls_jalr}
                         || (op_class == cls_branch && taken);
            end else if (mem_ready) begin
                ready <= 1'b1; // Two cycles after the grant
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en && !ready) begin
            if (is_mem) begin
                if (mem_ready)
                    val <= data_in;
            end else begin
                case (op_class)
                    cls_lui: val <= imm;
                    cls_auipc: val <= pc + imm;
                    cls_jal, cls_jalr: val <= link;
                    cls_alu: val <= alu_res;
                    default: val <= '0;
                endcase
                pc_out <= (op_class == cls_jalr) ? {mem_addr[M_WIDTH-1:1], 1'b0} : pc + imm;
            end
        end
    end

    mem_only_for_ld_st: assert property (@(posedge clk) disable iff (rst)
        mem_ready |-> en && !ready && op_class inside {cls_load, cls_store});

endmodule

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  inst_t     inst,
    output op_class_t op_class,
    output alu_fn_t   alu_fn,
    output reg_addr_t rd,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output word_t     imm,
    output logic      ready
);

    op_class_t cls_d;
    alu_fn_t fn_d;
    word_t imm_d;
    reg_addr_t rs2_d;

    function automatic alu_fn_t int_fn(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000: return sub ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b100: return alu_xor;
            3'b101: return alu_srl;
            3'b110: return alu_or;
            3'b111: return alu_and;
            default: return alu_add;
        endcase
    endfunction

    function automatic alu_fn_t br_fn(input logic [2:0] f3);
        case (f3)
            3'b001: return alu_bne;
            3'b100: return alu_blt;
            3'b101: return alu_bge;
            default: return alu_beq;
        endcase
    endfunction

    // Unused ALU operand is zeroed so exec can add rs2 and imm
    always_comb begin
        cls_d = cls_none;
        fn_d = alu_add;
        imm_d = inst[27:20]; // I-type
        rs2_d = inst[23:20];
        case (inst[6:0])
            OP_LUI: begin
                cls_d = cls_lui;
                imm_d = inst[19:12];
            end
            OP_AUIPC: begin
                cls_d = cls_auipc;
                imm_d = inst[19:12];
            end
            OP_JAL: begin
                cls_d = cls_jal;
                imm_d = {inst[27:21], 1'b0};
            end
            OP_JALR: cls_d = cls_jalr;
            OP_LOAD: cls_d = cls_load;
            OP_STORE: begin
                cls_d = cls_store;
                imm_d = {inst[27:25], inst[11:7]};
            end
            OP_BRANCH: begin
                cls_d = cls_branch;
                fn_d = br_fn(inst[14:12]);
                imm_d = {inst[27:25], inst[11:8], 1'b0};
            end
            OP_INTEGER_IMM: begin
                cls_d = cls_alu;
                fn_d = int_fn(inst[14:12], 1'b0);
                rs2_d = '0;
            end
            OP_INTEGER: begin
                cls_d = cls_alu;
                fn_d = int_fn(inst[14:12], inst[30]);
                imm_d = '0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            ready <= 1'b0;
        else
            ready <= en;
    end

    always_ff @(posedge clk) begin
        if (en && !ready) begin
            op_class <= cls_d;
            alu_fn <= fn_d;
            rd <= inst[10:7];
            rs1 <= inst[18:15];
            rs2 <= rs2_d;
            imm <= imm_d;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  en,
    input  word_t pc,
    input  word_t data_in,
    input  logic  mem_ready,
    output logic  mem_req,
    output word_t addr,
    output inst_t inst,
    output logic  ready
);

    logic [1:0] byte_cnt;

    assign mem_req = en && !ready;
    assign addr = pc + word_t'(byte_cnt);

    always_ff @(posedge clk) begin
        if (rst || !en) begin // Drops any pulse left over from a flush
            byte_cnt <= '0;
            ready <= 1'b0;
        end else if (mem_ready && !ready) begin
            byte_cnt <= byte_cnt + 2'd1;
            ready <= byte_cnt == 2'd3;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !ready && mem_ready)
            inst[M_WIDTH*byte_cnt +: M_WIDTH] <= data_in; // Little-endian
    end

endmodule

`default_nettype wire

//--- source/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

module mem_if import core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_req,
    input  word_t fetch_addr,
    input  logic  exec_req,
    input  word_t exec_addr,
    input  logic  exec_we,
    input  word_t exec_wdata,
    output logic  fetch_ready,
    output logic  exec_ready,
    output word_t addr,
    output logic  we,
    output word_t data_out
);

    logic go;

    // No grant during a ready pulse since the requests are still the old ones
    assign go = !(fetch_ready || exec_ready) && (fetch_req || exec_req);
    assign addr = !go ? '0 : exec_req ? exec_addr : fetch_addr;
    assign we = go && exec_req && exec_we;
    assign data_out = (go && exec_req) ? exec_wdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ready <= 1'b0;
            exec_ready <= 1'b0;
        end else begin
            fetch_ready <= go && !exec_req;
            exec_ready <= go && exec_req; // Exec wins a tie
        end
    end

    // Exec waits out at most one fetch pulse
    exec_granted_promptly: assert property (@(posedge clk) disable iff (rst)
        $rose(exec_req) |-> ##[1:2] exec_ready);

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int M_WIDTH = 8;
    localparam int INST_WIDTH = 32;
    localparam int INST_BYTES = 4;
    localparam int REG_CNT = 16;

    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_INTEGER_IMM = 7'b0010011;
    localparam logic [6:0] OP_INTEGER = 7'b0110011;

    typedef logic [M_WIDTH-1:0] word_t;
    typedef logic [INST_WIDTH-1:0] inst_t;
    typedef logic [$clog2(REG_CNT)-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        cls_none, cls_lui, cls_auipc, cls_jal, cls_jalr,
        cls_load, cls_store, cls_branch, cls_alu
    } op_class_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_slt, alu_sll, alu_srl,
        alu_beq, alu_bne, alu_blt, alu_bge
    } alu_fn_t;

    // Encoded as {en, ready}
    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_resetting = 2'b01,
        st_busy = 2'b10,
        st_complete = 2'b11
    } stage_state_t;

endpackage

`default_nettype wire
